/* compile.f */
logic/flowMuxPkg.sv
logic/rrArbiter.sv
logic/flowArbCore.sv
logic/onehotMux.sv
logic/flowMuxCore.sv
logic/flowMux.sv
verification/tbFlowMux.sv

/* logic/flowArbCore.sv */
// Purely combinational, and it relies on a grant that is one-hot or zero and zero only without requests
`timescale 1ns/1ns
`default_nettype none

module flowArbCore (
  input  flowMuxPkg::flowVecT pushValid,
  input  logic                popReady,
  input  flowMuxPkg::flowVecT grant,
  output flowMuxPkg::flowVecT request,
  output logic                enablePriorityUpdate,
  output flowMuxPkg::flowVecT pushReady,
  output logic                popValidUnstable
);

  // --------------------
  // Request side
  // --------------------

  // Every valid flow competes for the output
  assign request = pushValid;

  // --------------------
  // Handshake
  // --------------------

  // Only the granted flow sees ready
  // Ready from the consumer passes straight through
  assign pushReady = grant & {flowMuxPkg::NumFlows{popReady}};

  // Some flow is granted whenever any flow is valid
  // Pop valid can drop if that flow withdraws
  assign popValidUnstable = |grant;

  // --------------------
  // Priority update
  // --------------------

  // Move the round-robin order only when a word actually leaves
  // Stalls keep the order so the winner may change freely
  assign enablePriorityUpdate = popValidUnstable & popReady;

endmodule : flowArbCore

`default_nettype wire

/* logic/flowMux.sv */
// Pop valid and data are unstable while popReady is low and a higher priority flow may preempt
`timescale 1ns/1ns
`default_nettype none

module flowMux (
  input  logic                 clk,
  input  logic                 rstN,
  input  flowMuxPkg::flowVecT  pushValid,
  input  flowMuxPkg::flowDataT pushData,
  output flowMuxPkg::flowVecT  pushReady,
  input  logic                 popReady,
  output logic                 popValidUnstable,
  output flowMuxPkg::dataT     popDataUnstable
);

  // --------------------
  // Arbiter link
  // --------------------

  flowMuxPkg::flowVecT request;
  flowMuxPkg::flowVecT grant;
  logic                enablePriorityUpdate;

  // Zero-latency mux with the arbiter kept outside
  flowMuxCore core0 (
    .clk                  (clk),
    .rstN                 (rstN),
    .request              (request),
    .grant                (grant),
    .enablePriorityUpdate (enablePriorityUpdate),
    .pushReady            (pushReady),
    .pushValid            (pushValid),
    .pushData             (pushData),
    .popReady             (popReady),
    .popValidUnstable     (popValidUnstable),
    .popDataUnstable      (popDataUnstable)
  );

  // Round-robin choice with one pointer register
  rrArbiter arbiter0 (
    .clk                  (clk),
    .rstN                 (rstN),
    .request              (request),
    .enablePriorityUpdate (enablePriorityUpdate),
    .grant                (grant)
  );

endmodule : flowMux

`default_nettype wire

/* logic/flowMuxCore.sv */
// Needs an external arbiter for grant, and clk and rstN are carried but unused by its combinational logic
`timescale 1ns/1ns
`default_nettype none

module flowMuxCore (
  input  logic                 clk,
  input  logic                 rstN,
  // Arbiter side
  output flowMuxPkg::flowVecT  request,
  input  flowMuxPkg::flowVecT  grant,
  output logic                 enablePriorityUpdate,
  // Push side
  output flowMuxPkg::flowVecT  pushReady,
  input  flowMuxPkg::flowVecT  pushValid,
  input  flowMuxPkg::flowDataT pushData,
  // Pop side
  input  logic                 popReady,
  output logic                 popValidUnstable,
  output flowMuxPkg::dataT     popDataUnstable
);

  // --------------------
  // Control path
  // --------------------

  // Valid, ready and priority update from the shared grant
  flowArbCore arbCore0 (
    .pushValid            (pushValid),
    .popReady             (popReady),
    .grant                (grant),
    .request              (request),
    .enablePriorityUpdate (enablePriorityUpdate),
    .pushReady            (pushReady),
    .popValidUnstable     (popValidUnstable)
  );

  // --------------------
  // Data path
  // --------------------

  // Same grant picks the word
  // The popped word always belongs to the flow whose ready is high
  onehotMux dataMux0 (
    .select (grant),
    .in     (pushData),
    .out    (popDataUnstable)
  );

endmodule : flowMuxCore

`default_nettype wire

/* logic/flowMuxPkg.sv */
// Fixes one build of four flows with 16-bit words, and FlowIdxWidth must be wide enough for NumFlows
`default_nettype none

package flowMuxPkg;

  // --------------------
  // Sizes
  // --------------------

  // Number of push flows into the mux
  localparam int NumFlows = 4;

  // Bits in one data word
  localparam int DataWidth = 16;

  // Bits needed to name one flow
  localparam int FlowIdxWidth = 2;

  // --------------------
  // Types
  // --------------------

  // One bit per flow, used for request, grant, valid and ready
  typedef logic [NumFlows-1:0] flowVecT;

  // Flow number, as held by the round-robin pointer
  typedef logic [FlowIdxWidth-1:0] flowIdxT;

  // A single data word
  typedef logic [DataWidth-1:0] dataT;

  // All push words side by side, flow 0 in the low bits
  typedef logic [NumFlows*DataWidth-1:0] flowDataT;

endpackage : flowMuxPkg

`default_nettype wire

/* logic/onehotMux.sv */
// Select must be one-hot or zero, since two set bits OR their words together
`timescale 1ns/1ns
`default_nettype none

module onehotMux (
  input  flowMuxPkg::flowVecT  select,
  input  flowMuxPkg::flowDataT in,
  output flowMuxPkg::dataT     out
);

  // --------------------
  // AND-OR select
  // --------------------

  // Gate each word by its select bit, then fold with OR
  // Empty select yields an all-zero word
  always_comb begin
    flowMuxPkg::dataT word;
    out  = '0;
    word = '0;
    for (int i = 0; i < flowMuxPkg::NumFlows; i++) begin
      // Slice flow i out of the packed input
      word = in[i*flowMuxPkg::DataWidth +: flowMuxPkg::DataWidth];
      out  = out | (word & {flowMuxPkg::DataWidth{select[i]}});
    end
  end

endmodule : onehotMux

`default_nettype wire

/* logic/rrArbiter.sv */
// Grant is combinational from request, so it may move between edges, and the pointer only moves on enable
`timescale 1ns/1ns
`default_nettype none

module rrArbiter (
  input  logic                clk,
  input  logic                rstN,
  input  flowMuxPkg::flowVecT request,
  input  logic                enablePriorityUpdate,
  output flowMuxPkg::flowVecT grant
);

  // --------------------
  // Pointer state
  // --------------------

  // Index of the flow served most recently
  flowMuxPkg::flowIdxT ptrQ;

  // Index of the current winner, valid when anyGrant is high
  flowMuxPkg::flowIdxT winIdx;

  // High when some flow holds the grant
  logic anyGrant;

  // --------------------
  // Rotated search
  // --------------------

  // Start one past the pointer and take the first request found
  // Walks all NumFlows positions, so the pointer's own flow comes last
  always_comb begin
    int pos;
    logic found;
    grant  = '0;
    winIdx = '0;
    found  = 1'b0;
    pos    = 0;
    for (int off = 1; off <= flowMuxPkg::NumFlows; off++) begin
      // Wrap the position back into range
      pos = (int'(ptrQ) + off) % flowMuxPkg::NumFlows;
      if (!found && request[pos]) begin
        found       = 1'b1;
        grant[pos]  = 1'b1;
        winIdx      = flowMuxPkg::flowIdxT'(pos);
      end
    end
  end

  // Grant is zero exactly when no flow requests
  assign anyGrant = |grant;

  // --------------------
  // Pointer update
  // --------------------

  // Reset value makes flow 0 the first in line
  // A stalled grant leaves the order untouched
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      ptrQ <= flowMuxPkg::flowIdxT'(flowMuxPkg::NumFlows - 1);
    end else if (enablePriorityUpdate && anyGrant) begin
      // Winner becomes the lowest priority next cycle
      ptrQ <= winIdx;
    end
  end

endmodule : rrArbiter

`default_nettype wire

/* run.sh */
#!/bin/sh
# Builds the flow mux testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log
EXE=simFlowMux

verilator --binary --timing -f compile.f --top-module tbFlowMux \
  -Mdir "$BUILD_DIR" -o "$EXE"
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$BUILD_DIR/$EXE" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "^ALL CHECKS PASSED$" "$LOG"; then
  echo "Result: pass"
  exit 0
else
  echo "Result: fail"
  exit 1
fi

/* verification/tbFlowMux.sv */
// Needs the 4-flow, 16-bit build with a 2-bit flow index on top of each word, and runs one fixed seed
`timescale 1ns/1ns
`default_nettype none

module tbFlowMux;

  localparam int NumFlows = flowMuxPkg::NumFlows;
  localparam int DataWidth = flowMuxPkg::DataWidth;
  localparam int SeqWidth = flowMuxPkg::DataWidth - flowMuxPkg::FlowIdxWidth;
  localparam int HalfPeriod = 10;
  localparam int DriveDelay = 2;
  localparam int SampleDelay = 19;
  localparam int ExpectDelay = 5;
  localparam int RandomCycles = 1500;
  localparam int MaxCycles = 3000;
  localparam int ValidPct = 50;
  localparam int ReadyPct = 60;
  localparam int ModeDirected = 0;
  localparam int ModeRandom = 1;
  localparam int ModeDrain = 2;

  typedef logic [SeqWidth-1:0] seqT;

  logic                 clk;
  logic                 rstN;
  flowMuxPkg::flowVecT  pushValid;
  flowMuxPkg::flowDataT pushData;
  flowMuxPkg::flowVecT  pushReady;
  logic                 popReady;
  logic                 popValidUnstable;
  flowMuxPkg::dataT     popDataUnstable;

  // Testbench state
  flowMuxPkg::flowIdxT ptrCopy;
  flowMuxPkg::flowVecT acceptedVec;
  int sendSeq [NumFlows];
  int rcvSeq [NumFlows];
  int valueErrors;
  int orderErrors;
  int cycleCount;

  flowMux dut0 (
    .clk              (clk),
    .rstN             (rstN),
    .pushValid        (pushValid),
    .pushData         (pushData),
    .pushReady        (pushReady),
    .popReady         (popReady),
    .popValidUnstable (popValidUnstable),
    .popDataUnstable  (popDataUnstable)
  );

  initial begin
    clk = 1'b0;
    forever #HalfPeriod clk = ~clk;
  end

  // --------------------
  // Reference model
  // --------------------

  // Flow number on top of the sequence count
  function automatic flowMuxPkg::dataT wordOf(input int f);
    return {flowMuxPkg::flowIdxT'(f), seqT'(sendSeq[f])};
  endfunction

  // Count upward from pointer plus one and take the first valid flow
  function automatic void refModel(input flowMuxPkg::flowIdxT ptr,
                                   input flowMuxPkg::flowVecT valid, input logic rdy,
                                   input flowMuxPkg::flowDataT data, output int idx,
                                   output logic vld, output flowMuxPkg::dataT word,
                                   output flowMuxPkg::flowVecT rdyVec);
    int cand;
    idx = -1;
    vld = 1'b0;
    word = '0;
    rdyVec = '0;
    cand = int'(ptr);
    repeat (NumFlows) begin
      cand = (cand + 1 == NumFlows) ? 0 : cand + 1;
      if (idx < 0 && valid[cand]) idx = cand;
    end
    if (idx >= 0) begin
      vld = 1'b1;
      word = data[idx*DataWidth +: DataWidth];
      rdyVec[idx] = rdy;
    end
  endfunction

  // --------------------
  // Checker
  // --------------------

  // Compares one cycle just before the edge that completes it
  task automatic compareOutputs();
    int expIdx;
    int f;
    int seq;
    logic expVld;
    flowMuxPkg::dataT expData;
    flowMuxPkg::flowVecT expRdy;
    if (!rstN) ptrCopy = flowMuxPkg::flowIdxT'(NumFlows - 1);
    refModel(ptrCopy, pushValid, popReady, pushData, expIdx, expVld, expData, expRdy);
    if (pushReady !== expRdy) begin
      valueErrors++;
      $display("ERROR at %0t: pushReady %b, expected %b", $time, pushReady, expRdy);
    end
    if (popValidUnstable !== expVld) begin
      valueErrors++;
      $display("ERROR at %0t: popValid %b, expected %b", $time, popValidUnstable, expVld);
    end
    if (expVld && popDataUnstable !== expData) begin
      valueErrors++;
      $display("ERROR at %0t: popData %h, expected %h", $time, popDataUnstable, expData);
    end
    acceptedVec = rstN ? (pushValid & pushReady) : '0;
    // Pop handshake at the coming edge
    if (rstN && popValidUnstable && popReady) begin
      f = int'(popDataUnstable[DataWidth-1 -: flowMuxPkg::FlowIdxWidth]);
      seq = int'(popDataUnstable[SeqWidth-1:0]);
      if (seq != rcvSeq[f]) begin
        orderErrors++;
        $display("ERROR at %0t: flow %0d popped seq %0d, expected %0d", $time, f, seq, rcvSeq[f]);
      end
      rcvSeq[f] = seq + 1;
      if (expIdx >= 0) ptrCopy = flowMuxPkg::flowIdxT'(expIdx);
    end
  endtask

  initial begin
    forever begin
      @(posedge clk);
      #SampleDelay;
      compareOutputs();
    end
  end

  // A stuck handshake ends the run here
  always @(posedge clk) begin
    cycleCount = cycleCount + 1;
    if (cycleCount >= MaxCycles) begin
      $display("Timeout: run did not finish within %0d cycles", MaxCycles);
      $display("CHECKS FAILED");
      $finish;
    end
  end

  // --------------------
  // Stimulus
  // --------------------

  // One cycle of sources and sink where words advance after acceptance
  task automatic stepCycle(input flowMuxPkg::flowVecT want, input logic rdy, input int mode);
    flowMuxPkg::flowVecT nextValid;
    @(posedge clk);
    #DriveDelay;
    nextValid = want;
    for (int i = 0; i < NumFlows; i++) begin
      if (acceptedVec[i]) sendSeq[i]++;
      // Pending words stay valid outside directed tests
      if (mode != ModeDirected) begin
        if (pushValid[i] && !acceptedVec[i]) nextValid[i] = 1'b1;
        else if (mode == ModeRandom) nextValid[i] = (($urandom % 100) < ValidPct);
        else nextValid[i] = 1'b0;
      end
      pushData[i*DataWidth +: DataWidth] = wordOf(i);
    end
    pushValid = nextValid;
    if (mode == ModeRandom) popReady = (($urandom % 100) < ReadyPct);
    else if (mode == ModeDrain) popReady = 1'b1;
    else popReady = rdy;
  endtask

  // Directed check inside the current cycle
  task automatic expectOutputs(input flowMuxPkg::flowVecT expRdy, input logic expVld,
                               input int expFlow);
    #ExpectDelay;
    if (pushReady !== expRdy || popValidUnstable !== expVld) begin
      valueErrors++;
      $display("ERROR at %0t: ready %b valid %b, expected %b %b", $time, pushReady,
               popValidUnstable, expRdy, expVld);
    end
    if (expVld && popDataUnstable !== wordOf(expFlow)) begin
      valueErrors++;
      $display("ERROR at %0t: popData %h, expected flow %0d word", $time, popDataUnstable, expFlow);
    end
  endtask

  initial begin
    void'($urandom(32'h361732c0));
    rstN = 1'b0;
    pushValid = '0;
    pushData = '0;
    popReady = 1'b0;
    acceptedVec = '0;
    ptrCopy = flowMuxPkg::flowIdxT'(NumFlows - 1);
    valueErrors = 0;
    orderErrors = 0;
    cycleCount = 0;
    for (int i = 0; i < NumFlows; i++) begin
      sendSeq[i] = 0;
      rcvSeq[i] = 0;
    end
    repeat (2) @(posedge clk);
    #DriveDelay;
    rstN = 1'b1;
    // Reset state
    stepCycle(4'b0000, 1'b0, ModeDirected);
    expectOutputs(4'b0000, 1'b0, 0);
    // Flow 0 leads right after reset
    stepCycle(4'b1111, 1'b0, ModeDirected);
    expectOutputs(4'b0000, 1'b1, 0);
    // Single flow pass-through
    repeat (3) begin
      stepCycle(4'b0100, 1'b1, ModeDirected);
      expectOutputs(4'b0100, 1'b1, 2);
    end
    // Serve flow 3 so flow 0 leads the rotation
    stepCycle(4'b1000, 1'b1, ModeDirected);
    expectOutputs(4'b1000, 1'b1, 3);
    for (int k = 0; k < 8; k++) begin
      stepCycle(4'b1111, 1'b1, ModeDirected);
      expectOutputs(flowMuxPkg::flowVecT'(1 << (k % NumFlows)), 1'b1, k % NumFlows);
    end
    // Pointer on flow 0, then stall with flow 3 waiting
    stepCycle(4'b0001, 1'b1, ModeDirected);
    expectOutputs(4'b0001, 1'b1, 0);
    repeat (2) begin
      stepCycle(4'b1000, 1'b0, ModeDirected);
      expectOutputs(4'b0000, 1'b1, 3);
    end
    // Flow 1 preempts, flow 3 withdraws for a cycle
    stepCycle(4'b1010, 1'b0, ModeDirected);
    expectOutputs(4'b0000, 1'b1, 1);
    stepCycle(4'b0010, 1'b0, ModeDirected);
    expectOutputs(4'b0000, 1'b1, 1);
    stepCycle(4'b1010, 1'b1, ModeDirected);
    expectOutputs(4'b0010, 1'b1, 1);
    stepCycle(4'b1010, 1'b1, ModeDirected);
    expectOutputs(4'b1000, 1'b1, 3);
    // Random traffic, then drain every pending word
    repeat (RandomCycles) stepCycle('0, 1'b0, ModeRandom);
    do begin
      stepCycle('0, 1'b1, ModeDrain);
    end while (pushValid != '0);
    @(posedge clk);
    for (int i = 0; i < NumFlows; i++) begin
      if (rcvSeq[i] != sendSeq[i]) begin
        orderErrors++;
        $display("ERROR at %0t: flow %0d sent %0d words, popped %0d", $time, i, sendSeq[i],
                 rcvSeq[i]);
      end
    end
    $display("Value errors: %0d, order errors: %0d", valueErrors, orderErrors);
    if (valueErrors == 0 && orderErrors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule : tbFlowMux

`default_nettype wire
